//--- Bender.yml
package:
  name: mdu

sources:
  - src/cpu_word_pkg.sv
  - src/mdu_pkg.sv
  - src/md_multiplier.sv
  - src/md_divider.sv
  - src/md_issue.sv
  - src/mdu_top.sv
  - target: test
    files:
      - tb/mdu_tb.sv

//--- build.f
src/cpu_word_pkg.sv
src/mdu_pkg.sv
src/md_multiplier.sv
src/md_divider.sv
src/md_issue.sv
src/mdu_top.sv
tb/mdu_tb.sv

//--- src/cpu_word_pkg.sv
package cpu_word_pkg;

    // width of one general purpose register
    localparam int word_w = 32;

    // register or operand value
    typedef logic [word_w-1:0] word_t;

    // {hi, lo} pair, also a full 64-bit product
    typedef logic [2*word_w-1:0] dword_t;

endpackage

//--- src/md_divider.sv
`timescale 1ns/1ns

module md_divider (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                start,
    input  logic                signed_mode,
    input  cpu_word_pkg::word_t dividend,
    input  cpu_word_pkg::word_t divisor,
    output logic                busy,
    output logic                done,
    output mdu_pkg::md_res_t    quot_rem
);

    mdu_pkg::div_state_e state;
    mdu_pkg::div_cnt_t   cnt;

    logic                signed_r;
    logic                sign_q;
    logic                sign_r;
    // quot starts out holding the dividend, bits shift out as quotient bits shift in
    cpu_word_pkg::word_t quot;
    cpu_word_pkg::word_t rem;
    cpu_word_pkg::word_t dvs;

    logic                        neg_dvd;
    logic                        neg_dvs;
    logic [cpu_word_pkg::word_w:0] rem_shift;
    logic [cpu_word_pkg::word_w:0] diff;

    assign neg_dvd = signed_r & quot[cpu_word_pkg::word_w-1];
    assign neg_dvs = signed_r & dvs[cpu_word_pkg::word_w-1];

    assign rem_shift = {rem, quot[cpu_word_pkg::word_w-1]};
    assign diff      = rem_shift - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= mdu_pkg::DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                mdu_pkg::DIV_IDLE: begin
                    if (start) begin
                        state <= mdu_pkg::DIV_SETUP;
                    end
                end
                mdu_pkg::DIV_SETUP: begin
                    cnt   <= '0;
                    state <= mdu_pkg::DIV_RUN;
                end
                mdu_pkg::DIV_RUN: begin
                    if (cnt == mdu_pkg::div_cnt_t'(mdu_pkg::div_iter_n - 1)) begin
                        state <= mdu_pkg::DIV_FIX;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                mdu_pkg::DIV_FIX: begin
                    state <= mdu_pkg::DIV_DONE;
                end
                default: begin
                    state <= mdu_pkg::DIV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            mdu_pkg::DIV_IDLE: begin
                if (start) begin
                    signed_r <= signed_mode;
                    quot     <= dividend;
                    dvs      <= divisor;
                end
            end
            mdu_pkg::DIV_SETUP: begin
                quot   <= neg_dvd ? -quot : quot;
                dvs    <= neg_dvs ? -dvs : dvs;
                rem    <= '0;
                // x/0 keeps an all-ones quotient whatever the signs
                sign_q <= (neg_dvd ^ neg_dvs) && (dvs != '0);
                sign_r <= neg_dvd;
            end
            mdu_pkg::DIV_RUN: begin
                if (!diff[cpu_word_pkg::word_w]) begin
                    rem  <= diff[cpu_word_pkg::word_w-1:0];
                    quot <= {quot[cpu_word_pkg::word_w-2:0], 1'b1};
                end else begin
                    rem  <= rem_shift[cpu_word_pkg::word_w-1:0];
                    quot <= {quot[cpu_word_pkg::word_w-2:0], 1'b0};
                end
            end
            mdu_pkg::DIV_FIX: begin
                // remainder follows the dividend sign
                quot <= sign_q ? -quot : quot;
                rem  <= sign_r ? -rem : rem;
            end
            default: begin
            end
        endcase
    end

    assign busy        = (state != mdu_pkg::DIV_IDLE);
    assign done        = (state == mdu_pkg::DIV_DONE);
    assign quot_rem.hi = rem;
    assign quot_rem.lo = quot;

    assert property (@(posedge clk) disable iff (rst)
        busy |-> !start)
        else $error("divider started while busy");

endmodule

//--- src/md_issue.sv
`timescale 1ns/1ns

module md_issue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  mdu_pkg::md_req_t     req,
    input  logic                 req_valid,
    output logic                 req_ready,
    output mdu_pkg::md_res_t     res,
    output logic                 res_valid,
    input  logic                 res_ready,
    output cpu_word_pkg::word_t  hi,
    output cpu_word_pkg::word_t  lo,
    output logic                 mul_start,
    output logic                 mul_signed,
    output cpu_word_pkg::word_t  mul_a,
    output cpu_word_pkg::word_t  mul_b,
    output logic                 mul_advance,
    input  logic                 mul_done,
    input  cpu_word_pkg::dword_t mul_prod,
    output logic                 div_start,
    output logic                 div_signed,
    output cpu_word_pkg::word_t  div_dividend,
    output cpu_word_pkg::word_t  div_divisor,
    input  logic                 div_busy,
    input  logic                 div_done,
    input  mdu_pkg::md_res_t     div_quot_rem
);

    logic       is_mul;
    logic       is_div;
    logic       accept;
    logic       base_ready;
    logic       order_ok;
    logic       mul_load;
    // bit 0 mirrors multiplier stage one, bit 1 stage two
    logic [1:0] mul_tag;
    logic       mul_inflight;

    assign is_mul = (req.op == mdu_pkg::MD_MULT) || (req.op == mdu_pkg::MD_MULTU);
    assign is_div = (req.op == mdu_pkg::MD_DIV) || (req.op == mdu_pkg::MD_DIVU);

    // a held result freezes the multiply pipeline
    assign mul_advance  = !res_valid || res_ready;
    assign mul_inflight = |mul_tag;

    // div_busy also covers the cycle the divide result is handed over
    assign base_ready = !flush && !div_busy && mul_advance;
    // divides and register writes wait for earlier results to leave
    assign order_ok   = is_mul || (!mul_inflight && !res_valid);
    assign req_ready  = base_ready && order_ok;
    assign accept     = req_valid && req_ready;

    assign mul_start    = accept && is_mul;
    assign mul_signed   = (req.op == mdu_pkg::MD_MULT);
    assign mul_a        = req.src1;
    assign mul_b        = req.src2;
    assign div_start    = accept && is_div;
    assign div_signed   = (req.op == mdu_pkg::MD_DIV);
    assign div_dividend = req.src1;
    assign div_divisor  = req.src2;

    assign mul_load = mul_done && mul_advance;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            mul_tag <= 2'b00;
        end else if (mul_advance) begin
            mul_tag <= {mul_tag[0], mul_start};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            res_valid <= 1'b0;
        end else if (mul_load || div_done) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_load) begin
            res <= mdu_pkg::md_res_t'(mul_prod);
        end else if (div_done) begin
            res <= div_quot_rem;
        end
    end

    // hi/lo change together with the output register
    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (!flush && mul_load) begin
            hi <= mul_prod[2*cpu_word_pkg::word_w-1:cpu_word_pkg::word_w];
            lo <= mul_prod[cpu_word_pkg::word_w-1:0];
        end else if (!flush && div_done) begin
            hi <= div_quot_rem.hi;
            lo <= div_quot_rem.lo;
        end else if (accept && req.op == mdu_pkg::MD_MTHI) begin
            hi <= req.src1;
        end else if (accept && req.op == mdu_pkg::MD_MTLO) begin
            lo <= req.src1;
        end
    end

    assert property (@(posedge clk) disable iff (rst || flush)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else $error("result changed before it was taken");

    assert property (@(posedge clk) disable iff (rst)
        !(mul_done && div_done))
        else $error("multiply and divide finished together");

endmodule

//--- src/md_multiplier.sv
`timescale 1ns/1ns

module md_multiplier (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 start,
    input  logic                 signed_mode,
    input  cpu_word_pkg::word_t  a,
    input  cpu_word_pkg::word_t  b,
    input  logic                 advance,
    output logic                 done,
    output cpu_word_pkg::dword_t prod
);

    // stage one holds operands and mode
    logic                s1_valid;
    logic                s1_signed;
    cpu_word_pkg::word_t s1_a;
    cpu_word_pkg::word_t s1_b;

    // stage two holds the finished product
    logic                 s2_valid;
    cpu_word_pkg::dword_t s2_prod;

    // one signed 33x33 multiply serves both modes
    logic signed [cpu_word_pkg::word_w:0]     ext_a;
    logic signed [cpu_word_pkg::word_w:0]     ext_b;
    logic signed [2*cpu_word_pkg::word_w+1:0] full_prod;

    assign ext_a     = {s1_signed & s1_a[cpu_word_pkg::word_w-1], s1_a};
    assign ext_b     = {s1_signed & s1_b[cpu_word_pkg::word_w-1], s1_b};
    assign full_prod = ext_a * ext_b;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= start;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_signed <= signed_mode;
            s1_a      <= a;
            s1_b      <= b;
            s2_prod   <= full_prod[2*cpu_word_pkg::word_w-1:0];
        end
    end

    assign done = s2_valid;
    assign prod = s2_prod;

    // an op that advances twice reaches the output stage
    assert property (@(posedge clk) disable iff (rst || flush)
        start && advance ##1 advance |=> done)
        else $error("multiplier lost an operation");

endmodule

//--- src/mdu_pkg.sv
package mdu_pkg;

    // operations handled by the multiply/divide unit
    typedef enum logic [2:0] {
        MD_MULT,
        MD_MULTU,
        MD_DIV,
        MD_DIVU,
        MD_MTHI,
        MD_MTLO
    } md_op_e;

    // src1 is the dividend for divides and the write value for mthi/mtlo
    typedef struct packed {
        md_op_e              op;
        cpu_word_pkg::word_t src1;
        cpu_word_pkg::word_t src2;
    } md_req_t;

    // hi takes the upper product or the remainder
    typedef struct packed {
        cpu_word_pkg::word_t hi;
        cpu_word_pkg::word_t lo;
    } md_res_t;

    // one quotient bit per iteration
    localparam int div_iter_n = 32;

    typedef logic [5:0] div_cnt_t;

    typedef enum logic [2:0] {
        DIV_IDLE,
        DIV_SETUP,
        DIV_RUN,
        DIV_FIX,
        DIV_DONE
    } div_state_e;

endpackage

//--- src/mdu_top.sv
`timescale 1ns/1ns

module mdu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  mdu_pkg::md_req_t    req,
    input  logic                req_valid,
    output logic                req_ready,
    output mdu_pkg::md_res_t    res,
    output logic                res_valid,
    input  logic                res_ready,
    output cpu_word_pkg::word_t hi,
    output cpu_word_pkg::word_t lo
);

    logic                 mul_start;
    logic                 mul_signed;
    cpu_word_pkg::word_t  mul_a;
    cpu_word_pkg::word_t  mul_b;
    logic                 mul_advance;
    logic                 mul_done;
    cpu_word_pkg::dword_t mul_prod;

    logic                 div_start;
    logic                 div_signed;
    cpu_word_pkg::word_t  div_dividend;
    cpu_word_pkg::word_t  div_divisor;
    logic                 div_busy;
    logic                 div_done;
    mdu_pkg::md_res_t     div_quot_rem;

    md_issue issue_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .res          (res),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .hi           (hi),
        .lo           (lo),
        .mul_start    (mul_start),
        .mul_signed   (mul_signed),
        .mul_a        (mul_a),
        .mul_b        (mul_b),
        .mul_advance  (mul_advance),
        .mul_done     (mul_done),
        .mul_prod     (mul_prod),
        .div_start    (div_start),
        .div_signed   (div_signed),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .div_busy     (div_busy),
        .div_done     (div_done),
        .div_quot_rem (div_quot_rem)
    );

    md_multiplier multiplier_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (mul_start),
        .signed_mode (mul_signed),
        .a           (mul_a),
        .b           (mul_b),
        .advance     (mul_advance),
        .done        (mul_done),
        .prod        (mul_prod)
    );

    md_divider divider_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .start       (div_start),
        .signed_mode (div_signed),
        .dividend    (div_dividend),
        .divisor     (div_divisor),
        .busy        (div_busy),
        .done        (div_done),
        .quot_rem    (div_quot_rem)
    );

endmodule

//--- tb/mdu_tb.sv
`timescale 1ns/1ns

module mdu_tb;

    localparam int n_req       = 400;
    localparam int n_directed  = 8;
    localparam int cycle_limit = n_req * 40 + 500;

    logic                clk;
    logic                rst;
    logic                flush;
    mdu_pkg::md_req_t    req;
    logic                req_valid;
    logic                req_ready;
    mdu_pkg::md_res_t    res;
    logic                res_valid;
    logic                res_ready;
    cpu_word_pkg::word_t hi;
    cpu_word_pkg::word_t lo;

    // reference model state
    mdu_pkg::md_res_t    exp_q[$];
    mdu_pkg::md_res_t    exp_head;
    int                  exp_cnt = 0;
    cpu_word_pkg::word_t model_hi;
    cpu_word_pkg::word_t model_lo;
    logic                held_prev = 1'b0;
    int                  taken = 0;
    int                  cycles = 0;
    logic [31:0]         rng = 32'd77;

    logic req_xfer;
    logic mul_acc;
    logic div_acc;
    logic mt_acc;

    mdu_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .hi        (hi),
        .lo        (lo)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_fail(input string msg);
        abort_run($sformatf("Fail %0t ns: %s", $time, msg));
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // corner values show up often next to plain random words
    function automatic cpu_word_pkg::word_t pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: return '0;
            3'd1: return '1;
            3'd2: return 32'h8000_0000;
            3'd3: return {28'b0, r[11:8]};
            default: return next_rand();
        endcase
    endfunction

    function automatic mdu_pkg::md_req_t directed_req(input int idx);
        case (idx)
            0: return {mdu_pkg::MD_DIV, 32'h8000_0000, 32'hffff_ffff};
            1: return {mdu_pkg::MD_DIV, -32'sd7, 32'd0};
            2: return {mdu_pkg::MD_DIVU, 32'd123, 32'd0};
            3: return {mdu_pkg::MD_DIV, -32'sd7, 32'd2};
            4: return {mdu_pkg::MD_MULT, 32'h8000_0000, 32'h8000_0000};
            5: return {mdu_pkg::MD_MULTU, 32'hffff_ffff, 32'hffff_ffff};
            6: return {mdu_pkg::MD_MTHI, 32'h1234_5678, 32'd0};
            default: return {mdu_pkg::MD_MTLO, 32'h9abc_def0, 32'd0};
        endcase
    endfunction

    function automatic mdu_pkg::md_req_t random_req();
        mdu_pkg::md_req_t r;
        r.op   = mdu_pkg::md_op_e'(3'(next_rand() % 6));
        r.src1 = pick_operand();
        r.src2 = pick_operand();
        return r;
    endfunction

    // upper half to hi and lower half to lo
    function automatic mdu_pkg::md_res_t expect_mul(input logic sgn,
                                                   input cpu_word_pkg::word_t a,
                                                   input cpu_word_pkg::word_t b);
        logic [63:0] xa;
        logic [63:0] xb;
        xa = sgn ? {{32{a[31]}}, a} : {32'b0, a};
        xb = sgn ? {{32{b[31]}}, b} : {32'b0, b};
        return mdu_pkg::md_res_t'(xa * xb);
    endfunction

    // remainder to hi and quotient to lo
    function automatic mdu_pkg::md_res_t expect_div(input logic sgn,
                                                   input cpu_word_pkg::word_t a,
                                                   input cpu_word_pkg::word_t b);
        mdu_pkg::md_res_t r;
        if (b == '0) begin
            r.hi = a;
            r.lo = '1;
        end else if (!sgn) begin
            r.hi = a % b;
            r.lo = a / b;
        end else if (a == 32'h8000_0000 && b == '1) begin
            r.hi = '0;
            r.lo = a;
        end else begin
            r.hi = $signed(a) % $signed(b);
            r.lo = $signed(a) / $signed(b);
        end
        return r;
    endfunction

    assign req_xfer = req_valid && req_ready;
    assign mul_acc  = req_xfer && (req.op == mdu_pkg::MD_MULT || req.op == mdu_pkg::MD_MULTU);
    assign div_acc  = req_xfer && (req.op == mdu_pkg::MD_DIV || req.op == mdu_pkg::MD_DIVU);
    assign mt_acc   = req_xfer && (req.op == mdu_pkg::MD_MTHI || req.op == mdu_pkg::MD_MTLO);

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            model_hi  = '0;
            model_lo  = '0;
            held_prev = 1'b0;
        end else begin
            // a result not held last cycle is new and hi/lo follow it
            if (res_valid && !held_prev && exp_q.size() != 0) begin
                model_hi = exp_q[0].hi;
                model_lo = exp_q[0].lo;
            end
            if (res_valid && res_ready && exp_q.size() != 0) begin
                exp_q.pop_front();
            end
            if (flush) begin
                exp_q.delete();
            end
            if (req_xfer) begin
                taken = taken + 1;
                case (req.op)
                    mdu_pkg::MD_MULT:  exp_q.push_back(expect_mul(1'b1, req.src1, req.src2));
                    mdu_pkg::MD_MULTU: exp_q.push_back(expect_mul(1'b0, req.src1, req.src2));
                    mdu_pkg::MD_DIV:   exp_q.push_back(expect_div(1'b1, req.src1, req.src2));
                    mdu_pkg::MD_DIVU:  exp_q.push_back(expect_div(1'b0, req.src1, req.src2));
                    mdu_pkg::MD_MTHI:  model_hi = req.src1;
                    mdu_pkg::MD_MTLO:  model_lo = req.src1;
                    default: begin
                    end
                endcase
            end
            held_prev = res_valid && !res_ready && !flush;
        end
        exp_cnt  = exp_q.size();
        exp_head = (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) abort_run("timeout: results did not drain in time");
    end

    result_order: assert property (@(posedge clk) disable iff (rst)
        res_valid && res_ready |-> exp_cnt != 0 && res == exp_head)
        else value_fail("result differs from the reference model");

    fresh_hilo: assert property (@(posedge clk) disable iff (rst)
        res_valid && !held_prev |-> exp_cnt != 0 && hi == exp_head.hi && lo == exp_head.lo)
        else value_fail("hi/lo do not match the new result");

    move_hilo: assert property (@(posedge clk) disable iff (rst)
        mt_acc |=> hi == model_hi && lo == model_lo)
        else value_fail("hi/lo wrong after a register write");

    hold_result: assert property (@(posedge clk) disable iff (rst || flush)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else value_fail("result changed while stalled");

    after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !res_valid && req_ready && hi == '0 && lo == '0)
        else value_fail("wrong state after reset");

    after_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> !res_valid && $stable(hi) && $stable(lo) && exp_cnt == 0)
        else value_fail("flush left a result or touched hi/lo");

    mul_latency: assert property (@(posedge clk) disable iff (rst || flush)
        mul_acc ##1 res_ready ##1 res_ready |=> res_valid)
        else value_fail("multiply result not ready 2 cycles after issue");

    div_latency: assert property (@(posedge clk) disable iff (rst || flush)
        div_acc |-> ##35 !res_valid ##1 res_valid)
        else value_fail("divide result not ready 35 cycles after issue");

    initial begin
        int sent;
        int seen;
        int flush_cnt;
        sent      = 0;
        seen      = 0;
        flush_cnt = 0;
        rst       = 1'b1;
        flush     = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        res_ready = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (sent < n_req) begin
            if (req_valid && taken != seen) begin
                seen      = taken;
                sent      = sent + 1;
                req_valid = 1'b0;
            end
            res_ready = (next_rand() % 4) != 0;
            flush     = 1'b0;
            // a few flushes while results are still owed
            if (flush_cnt < 3 && sent >= (flush_cnt + 1) * 100 && exp_q.size() != 0) begin
                flush     = 1'b1;
                flush_cnt = flush_cnt + 1;
            end
            if (!req_valid && sent < n_req && (next_rand() % 4) != 0) begin
                req       = (sent < n_directed) ? directed_req(sent) : random_req();
                req_valid = 1'b1;
            end
            @(negedge clk);
        end
        flush     = 1'b0;
        res_ready = 1'b1;
        while (exp_q.size() != 0 || res_valid) @(negedge clk);
        repeat (40) @(negedge clk);
        if (exp_q.size() == 0 && !res_valid) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("results still pending at the end of the run");
        end
    end

endmodule
